// File: Bender.yml
package:
  name: frame_sync

sources:
  - hdl/nr_numerology_pkg.sv
  - hdl/sync_ctrl_pkg.sv
  - hdl/symbol_timing_if.sv
  - hdl/symbol_timer.sv
  - hdl/frame_tracker.sv
  - hdl/pss_scheduler.sv
  - hdl/stream_output.sv
  - hdl/frame_sync_top.sv
  - target: simulation
    files:
      - bench/frame_sync_props.sv
      - bench/tb_frame_sync.sv

// File: bench/frame_sync_props.sv
module frame_sync_props (
    input logic                          clk_i,
    input logic                          reset_ni,
    input logic                          m_axis_out_tvalid_o,
    input logic                          m_axis_out_tlast_o,
    input logic                          symbol_start_o,
    input logic                          ssb_start_o,
    input sync_ctrl_pkg::pss_mode_t      pss_detector_mode_o,
    input nr_numerology_pkg::tuser_t     m_axis_out_tuser_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import nr_numerology_pkg::*;

    int fail_count = 0;

    a_last_has_valid: assert property (@(posedge clk_i) disable iff (!reset_ni)
        m_axis_out_tlast_o |-> m_axis_out_tvalid_o)
        else begin
            $error("tlast is high without tvalid");
            fail_count++;
        end

    a_start_has_valid: assert property (@(posedge clk_i) disable iff (!reset_ni)
        symbol_start_o |-> m_axis_out_tvalid_o)
        else begin
            $error("symbol_start is high without tvalid");
            fail_count++;
        end

    // an SSB always begins on a symbol boundary
    a_ssb_on_symbol_start: assert property (@(posedge clk_i) disable iff (!reset_ni)
        ssb_start_o |-> symbol_start_o)
        else begin
            $error("SSB_start is high without symbol_start");
            fail_count++;
        end

    a_mode_legal: assert property (@(posedge clk_i) disable iff (!reset_ni)
        pss_detector_mode_o != 2'd3)
        else begin
            $error("PSS detector mode holds the unused code 3");
            fail_count++;
        end

    a_symbol_range: assert property (@(posedge clk_i) disable iff (!reset_ni)
        m_axis_out_tvalid_o |-> (m_axis_out_tuser_o.pos.symbol < symbol_t'(SYM_PER_SF)))
        else begin
            $error("tuser symbol field is out of range");
            fail_count++;
        end

endmodule

bind frame_sync_top frame_sync_props u_props (.*);

// File: bench/frame_sync_stimulus.txt
# name idle_samples ibar ibar_delay symbols gaps late_strobe exp_sfn exp_subframe exp_symbol
# the expected position is the tag of the first sample of the last streamed symbol
anchor_basic 40 0 10 2 0 0 0 0 5
stream_plain 5 0 300 30 0 0 0 2 5
stream_gaps 17 1 50 30 1 0 0 2 11
ibar_1 3 1 600 4 0 0 0 0 13
ibar_2 3 2 1 3 0 0 0 1 4
ibar_3 3 3 290 5 0 0 0 1 12
ibar_3_on_boundary 3 3 274 4 0 0 0 1 11
locked_late_strobe 9 0 20 6 0 1 0 0 9
sfn_carry 11 3 100 300 1 0 1 2 13

// File: bench/tb_frame_sync.sv
module tb_frame_sync;
    timeunit 1ns;
    timeprecision 1ps;
    import nr_numerology_pkg::*;
    import sync_ctrl_pkg::*;

    localparam int TIMEOUT = 200000;
    localparam int M_WAIT_SSB = 0;
    localparam int M_WAIT_IBAR = 1;
    localparam int M_SYNCED = 2;

    typedef struct {
        sample_t data;
        tuser_t  tuser;
        logic    first;
        logic    last;
        logic    ssb;
        int      due;
    } exp_t;

    logic clk_i = 1'b0;
    logic reset_ni = 1'b0;
    sample_t s_axis_in_tdata_i = '0;
    logic s_axis_in_tvalid_i = 1'b0;
    n_id_2_t n_id_2_i = '0;
    logic n_id_2_valid_i = 1'b0;
    ibar_t ibar_ssb_i = '0;
    logic ibar_ssb_valid_i = 1'b0;
    pss_mode_t pss_detector_mode_o;
    n_id_2_t requested_n_id_2_o;
    sample_t m_axis_out_tdata_o;
    tuser_t m_axis_out_tuser_o;
    logic m_axis_out_tlast_o;
    logic m_axis_out_tvalid_o;
    logic symbol_start_o;
    logic ssb_start_o;

    int seed = 32'h8948_655a;
    int cycle = 0;
    string cur_test = "none";
    int test_errors = 0;
    int total_errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    exp_t exp_q[$];
    tuser_t last_tuser;
    int data_cnt = 0;

    // reference model of the frame position, symbols counted from SFN 0
    int m_state;
    int m_idx;
    int m_cnt;
    int m_cp;
    int m_syms;

    frame_sync_top u_dut (.*);

    always #50 clk_i = ~clk_i;

    task automatic report_error(input string msg);
        $display("ERROR test=%s: %s", cur_test, msg);
        test_errors++;
    endtask

    task automatic check_sample(input string what, input sample_t exp, input sample_t act);
        if (exp !== act) begin
            $display("CHECK FAILED test=%s %s expected=%h actual=%h", cur_test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_tuser(input string what, input tuser_t exp, input tuser_t act);
        if (exp !== act) begin
            $display("CHECK FAILED test=%s %s expected=%h actual=%h", cur_test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_mode(input string what, input pss_mode_t exp, input pss_mode_t act);
        if (exp !== act) begin
            $display("CHECK FAILED test=%s %s expected=%0d actual=%0d", cur_test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_n_id_2(input string what, input n_id_2_t exp, input n_id_2_t act);
        if (exp !== act) begin
            $display("CHECK FAILED test=%s %s expected=%0d actual=%0d", cur_test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_strobe(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            $display("CHECK FAILED test=%s %s expected=%b actual=%b", cur_test, what, exp, act);
            test_errors++;
        end
    endtask

    // the symbol index gives symbol, subframe and SFN by plain division
    function automatic tuser_t make_tuser(input int idx, input int cp);
        tuser_t t;
        t.pos.symbol = symbol_t'(idx % 14);
        t.pos.subframe = subframe_t'((idx / 14) % 20);
        t.pos.sfn = sfn_t'((idx / 280) % 1024);
        t.cp_len = cp_len_t'(cp);
        return t;
    endfunction

    always @(posedge clk_i) begin : monitor_outputs
        exp_t e;
        cycle <= cycle + 1;
        if (reset_ni) begin
            if (m_axis_out_tvalid_o) begin
                if (exp_q.size() == 0) begin
                    report_error("output sample appeared while none was expected");
                end else begin
                    e = exp_q.pop_front();
                    if (e.due != cycle) begin
                        report_error($sformatf("sample came at cycle %0d, due at %0d",
                                               cycle, e.due));
                    end
                    check_sample("tdata", e.data, m_axis_out_tdata_o);
                    check_tuser("tuser", e.tuser, m_axis_out_tuser_o);
                    check_strobe("tlast", e.last, m_axis_out_tlast_o);
                    check_strobe("symbol_start", e.first, symbol_start_o);
                    check_strobe("SSB_start", e.ssb, ssb_start_o);
                    last_tuser = m_axis_out_tuser_o;
                end
            end else if (exp_q.size() > 0 && exp_q[0].due <= cycle) begin
                report_error("an expected output sample never appeared");
                void'(exp_q.pop_front());
            end
        end
    end

    task automatic apply_reset();
        @(posedge clk_i);
        reset_ni <= 1'b0;
        s_axis_in_tvalid_i <= 1'b0;
        n_id_2_valid_i <= 1'b0;
        ibar_ssb_valid_i <= 1'b0;
        exp_q.delete();
        m_state = M_WAIT_SSB;
        m_idx = 0;
        m_cnt = 0;
        m_cp = 18;
        m_syms = 0;
        repeat (8) @(posedge clk_i);
        reset_ni <= 1'b1;
    endtask

    // drives one cycle and predicts what the DUT sends out three edges later
    task automatic drive_cycle(input logic valid, input logic nv, input logic iv);
        sample_t sample;
        exp_t e;
        logic first;
        logic last;
        @(posedge clk_i);
        data_cnt++;
        sample = sample_t'(data_cnt) ^ sample_t'($random(seed));
        s_axis_in_tdata_i <= sample;
        s_axis_in_tvalid_i <= valid;
        n_id_2_valid_i <= nv;
        ibar_ssb_valid_i <= iv;
        e.data = sample;
        e.due = cycle + 3;
        if (m_state == M_WAIT_SSB) begin
            if (valid && nv) begin
                m_idx = (m_idx / 14) * 14 + 3;
                m_cp = 18;
                m_cnt = 1;
                m_state = M_WAIT_IBAR;
                e.tuser = make_tuser(m_idx, m_cp);
                e.first = 1'b1;
                e.last = 1'b0;
                e.ssb = 1'b1;
                exp_q.push_back(e);
            end
        end else begin
            first = valid && (m_cnt == 0);
            last = valid && (m_cnt == 255 + m_cp);
            e.ssb = valid && nv && (m_state != M_SYNCED);
            if (first) begin
                m_idx = (m_idx + 1) % (280 * 1024);
                m_syms++;
            end
            if (iv && m_state == M_WAIT_IBAR) begin
                m_idx = (m_idx + 6 * int'(ibar_ssb_i)) % (280 * 1024);
                m_state = M_SYNCED;
            end
            if (first) begin
                m_cp = ((m_idx % 14 == 0) || (m_idx % 14 == 7)) ? 20 : 18;
            end
            if (valid) begin
                m_cnt = last ? 0 : m_cnt + 1;
                e.tuser = make_tuser(m_idx, m_cp);
                e.first = first;
                e.last = last;
                exp_q.push_back(e);
            end
        end
    endtask

    task automatic wait_drain();
        int n;
        for (n = 0; n < TIMEOUT && exp_q.size() > 0; n++) begin
            @(posedge clk_i);
        end
        if (exp_q.size() > 0) begin
            report_error("timeout while waiting for the output stream to drain");
        end
    endtask

    task automatic run_record(input string name, input int idle, input int ibar,
                              input int delay, input int nsym, input int gaps,
                              input int late, input int e_sfn, input int e_sf, input int e_sym);
        int n;
        logic valid;
        logic nv;
        logic late_done;
        tuser_t exp_end;
        cur_test = name;
        test_errors = 0;
        late_done = 1'b0;
        apply_reset();
        ibar_ssb_i <= ibar_t'(ibar);
        n_id_2_i <= n_id_2_t'(tests_run % 3);
        for (n = 0; n < idle; n++) begin
            drive_cycle(!(gaps != 0 && ($random(seed) & 7) == 0), 1'b0, 1'b0);
        end
        drive_cycle(1'b1, 1'b1, 1'b0);
        n = 0;
        while (m_syms < nsym) begin
            n++;
            valid = !(gaps != 0 && ($random(seed) & 7) == 0);
            nv = late != 0 && !late_done && m_state == M_SYNCED && m_cnt == 100 && valid;
            if (nv) begin
                late_done = 1'b1;
            end
            drive_cycle(valid, nv, n == delay);
        end
        drive_cycle(1'b0, 1'b0, 1'b0);
        wait_drain();
        exp_end = make_tuser(e_sfn * 280 + e_sf * 14 + e_sym,
                             (e_sym == 0 || e_sym == 7) ? 20 : 18);
        check_tuser("end position", exp_end, last_tuser);
        finish_test();
    endtask

    task automatic strobe_n_id_2(input n_id_2_t value);
        @(posedge clk_i);
        n_id_2_i <= value;
        n_id_2_valid_i <= 1'b1;
        @(posedge clk_i);
        n_id_2_valid_i <= 1'b0;
        @(posedge clk_i);
        check_n_id_2("requested N_id_2", value, requested_n_id_2_o);
    endtask

    task automatic wait_mode(input pss_mode_t target, output int when);
        int n;
        for (n = 0; n < TIMEOUT; n++) begin
            @(posedge clk_i);
            if (pss_detector_mode_o == target) begin
                break;
            end
        end
        when = cycle;
        if (pss_detector_mode_o != target) begin
            report_error($sformatf("timeout while waiting for PSS mode %0d", target));
        end
    endtask

    task automatic check_delay(input string what, input int exp, input int act);
        if (act < exp - 2 || act > exp + 2) begin
            $display("CHECK FAILED test=%s %s expected=%0d actual=%0d", cur_test, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic run_pss_schedule();
        int t_pause;
        int t_find;
        int t_search;
        cur_test = "pss_schedule";
        test_errors = 0;
        apply_reset();
        @(posedge clk_i);
        check_mode("mode after reset", SEARCH, pss_detector_mode_o);
        check_n_id_2("requested N_id_2 after reset", 2'd0, requested_n_id_2_o);
        strobe_n_id_2(2'd2);
        wait_mode(PAUSE, t_pause);
        wait_mode(FIND, t_find);
        check_delay("cycles from PAUSE to FIND", 76800 - 384, t_find - t_pause);
        wait_mode(SEARCH, t_search);
        check_delay("cycles from PAUSE to SEARCH", 76800 + 384, t_search - t_pause);
        strobe_n_id_2(2'd1);
        wait_mode(PAUSE, t_pause);
        wait_mode(FIND, t_find);
        // a hit inside the FIND window puts the detector back to sleep
        strobe_n_id_2(2'd0);
        @(posedge clk_i);
        check_mode("mode after strobe in FIND", PAUSE, pss_detector_mode_o);
        finish_test();
    endtask

    task automatic finish_test();
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, test_errors);
        end
    endtask

    initial begin : main
        int fd;
        string line;
        string name;
        int f[9];
        fd = $fopen("bench/frame_sync_stimulus.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open the stimulus file");
            total_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line[0] != "#") begin
                    if ($sscanf(line, "%s %d %d %d %d %d %d %d %d %d", name, f[0], f[1],
                                f[2], f[3], f[4], f[5], f[6], f[7], f[8]) == 10) begin
                        run_record(name, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
                    end
                end
            end
            $fclose(fd);
        end
        run_pss_schedule();
        if (u_dut.u_props.fail_count != 0) begin
            $display("ERROR: %0d bound assertion failures", u_dut.u_props.fail_count);
            total_errors += u_dut.u_props.fail_count;
        end
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
        if (total_errors == 0 && tests_run > 1) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: build.f
hdl/nr_numerology_pkg.sv
hdl/sync_ctrl_pkg.sv
hdl/symbol_timing_if.sv
hdl/symbol_timer.sv
hdl/frame_tracker.sv
hdl/pss_scheduler.sv
hdl/stream_output.sv
hdl/frame_sync_top.sv
bench/frame_sync_props.sv
bench/tb_frame_sync.sv

// File: hdl/frame_sync_top.sv
module frame_sync_top (
    input  logic                          clk_i,
    input  logic                          reset_ni,
    input  sync_ctrl_pkg::sample_t        s_axis_in_tdata_i,
    input  logic                          s_axis_in_tvalid_i,
    input  sync_ctrl_pkg::n_id_2_t        n_id_2_i,
    input  logic                          n_id_2_valid_i,
    input  nr_numerology_pkg::ibar_t      ibar_ssb_i,
    input  logic                          ibar_ssb_valid_i,
    output sync_ctrl_pkg::pss_mode_t      pss_detector_mode_o,
    output sync_ctrl_pkg::n_id_2_t        requested_n_id_2_o,
    output sync_ctrl_pkg::sample_t        m_axis_out_tdata_o,
    output nr_numerology_pkg::tuser_t     m_axis_out_tuser_o,
    output logic                          m_axis_out_tlast_o,
    output logic                          m_axis_out_tvalid_o,
    output logic                          symbol_start_o,
    output logic                          ssb_start_o
);
    import nr_numerology_pkg::*;
    import sync_ctrl_pkg::*;

    sync_state_t sync_state;
    frame_pos_t  frame_pos;

    // per-sample symbol timing shared by timer, tracker and output stage
    symbol_timing_if timing_if ();

    assign timing_if.sample_valid = s_axis_in_tvalid_i;

    symbol_timer u_symbol_timer (
        .clk_i     (clk_i),
        .reset_ni  (reset_ni),
        .timing_io (timing_if.timer),
        .state_i   (sync_state)
    );

    frame_tracker u_frame_tracker (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .timing_io      (timing_if.tracker),
        .n_id_2_valid_i (n_id_2_valid_i),
        .ibar_i         (ibar_ssb_i),
        .ibar_valid_i   (ibar_ssb_valid_i),
        .state_o        (sync_state),
        .pos_o          (frame_pos)
    );

    pss_scheduler u_pss_scheduler (
        .clk_i              (clk_i),
        .reset_ni           (reset_ni),
        .n_id_2_i           (n_id_2_i),
        .n_id_2_valid_i     (n_id_2_valid_i),
        .mode_o             (pss_detector_mode_o),
        .requested_n_id_2_o (requested_n_id_2_o)
    );

    stream_output u_stream_output (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .timing_io      (timing_if.out),
        .data_i         (s_axis_in_tdata_i),
        .n_id_2_valid_i (n_id_2_valid_i),
        .state_i        (sync_state),
        .pos_i          (frame_pos),
        .data_o         (m_axis_out_tdata_o),
        .tuser_o        (m_axis_out_tuser_o),
        .valid_o        (m_axis_out_tvalid_o),
        .last_o         (m_axis_out_tlast_o),
        .symbol_start_o (symbol_start_o),
        .ssb_start_o    (ssb_start_o)
    );

endmodule

// File: hdl/frame_tracker.sv
module frame_tracker (
    input  logic                           clk_i,
    input  logic                           reset_ni,
    symbol_timing_if.tracker               timing_io,
    input  logic                           n_id_2_valid_i,
    input  nr_numerology_pkg::ibar_t       ibar_i,
    input  logic                           ibar_valid_i,
    output sync_ctrl_pkg::sync_state_t     state_o,
    output nr_numerology_pkg::frame_pos_t  pos_o
);
    import nr_numerology_pkg::*;
    import sync_ctrl_pkg::*;

    sync_state_t state;
    frame_pos_t  pos;
    cp_len_t     cp_len;

    frame_pos_t  pos_adv;
    frame_pos_t  pos_next;
    logic        boundary;
    logic        ibar_fix;
    cp_len_t     cp_next;

    // moves a frame position on by n symbols, carrying into subframe and SFN
    function automatic frame_pos_t add_symbols(input frame_pos_t p, input logic [5:0] n);
        frame_pos_t r;
        logic [5:0] sym_sum;
        logic [5:0] sf_sum;
        sym_sum = 6'(p.symbol) + n;
        sf_sum = 6'(p.subframe) + 6'(sym_sum / SYM_PER_SF);
        r.symbol = symbol_t'(sym_sum % SYM_PER_SF);
        r.subframe = subframe_t'(sf_sum % SUBFRAMES_PER_FRAME);
        if (sf_sum >= SUBFRAMES_PER_FRAME) begin
            r.sfn = (p.sfn == sfn_t'(SFN_MAX - 1)) ? '0 : p.sfn + 1'b1;
        end else begin
            r.sfn = p.sfn;
        end
        return r;
    endfunction

    // first SSB sample while still searching fixes the symbol timing
    assign timing_io.anchor = timing_io.sample_valid && n_id_2_valid_i && (state == WAIT_SSB);
    assign timing_io.cp_len = cp_len;

    // the position always belongs to the most recently accepted sample,
    // so it steps on the first sample of each new symbol
    assign boundary = timing_io.first && (state != WAIT_SSB);
    assign ibar_fix = ibar_valid_i && (state == WAIT_IBAR);

    always_comb begin
        pos_adv = boundary ? add_symbols(pos, 6'd1) : pos;
        // boundary step goes first, the ibar offset is added on top
        pos_next = ibar_fix ? add_symbols(pos_adv, 6'(IBAR_SYM_STEP * ibar_i)) : pos_adv;
        if ((pos_next.symbol == '0) || (pos_next.symbol == symbol_t'(SYM_PER_SF / 2))) begin
            cp_next = CP1_LEN;
        end else begin
            cp_next = CP2_LEN;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state <= WAIT_SSB;
            pos <= '0;
            cp_len <= CP2_LEN;
        end else if (state == WAIT_SSB) begin
            if (timing_io.anchor) begin
                // subframe and SFN are kept until ibar_SSB corrects them
                pos.symbol <= SSB_FIRST_SYM;
                cp_len <= CP2_LEN;
                state <= WAIT_IBAR;
            end
        end else begin
            pos <= pos_next;
            if (boundary) begin
                cp_len <= cp_next;
            end
            if (ibar_fix) begin
                state <= SYNCED;
            end
        end
    end

    // the last flag only matters to the timer, the tracker reacts to first
    // so that each sample keeps the tag of its own symbol
    assign state_o = state;
    assign pos_o = pos;

endmodule

// File: hdl/nr_numerology_pkg.sv
package nr_numerology_pkg;

    // field types of the frame position and the symbol timing
    typedef logic [3:0] symbol_t;
    typedef logic [4:0] subframe_t;
    typedef logic [9:0] sfn_t;
    typedef logic [4:0] cp_len_t;
    typedef logic [8:0] sample_cnt_t;
    typedef logic [2:0] ibar_t;

    // 256-point FFT at 3.84 MHz sample rate
    localparam int unsigned FFT_LEN = 256;
    localparam cp_len_t CP1_LEN = 5'd20;
    localparam cp_len_t CP2_LEN = 5'd18;

    localparam int unsigned SYM_PER_SF = 14;
    localparam int unsigned SUBFRAMES_PER_FRAME = 20;
    localparam int unsigned SFN_MAX = 1024;

    // a fresh SSB is taken as symbol 3 until ibar_SSB tells otherwise
    localparam symbol_t SSB_FIRST_SYM = 4'd3;
    localparam int unsigned IBAR_SYM_STEP = 6;

    // position of a sample within the radio frame structure
    typedef struct packed {
        sfn_t      sfn;
        subframe_t subframe;
        symbol_t   symbol;
    } frame_pos_t;

    // tuser layout of the output stream, cp_len sits in the lowest bits
    typedef struct packed {
        frame_pos_t pos;
        cp_len_t    cp_len;
    } tuser_t;

endpackage

// File: hdl/pss_scheduler.sv
module pss_scheduler (
    input  logic                      clk_i,
    input  logic                      reset_ni,
    input  sync_ctrl_pkg::n_id_2_t    n_id_2_i,
    input  logic                      n_id_2_valid_i,
    output sync_ctrl_pkg::pss_mode_t  mode_o,
    output sync_ctrl_pkg::n_id_2_t    requested_n_id_2_o
);
    import sync_ctrl_pkg::*;

    pss_mode_t pss_state;
    // cycles since the last detected PSS
    pss_clk_t  clks_since_ssb;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            pss_state <= SEARCH;
            clks_since_ssb <= '0;
            mode_o <= SEARCH;
            requested_n_id_2_o <= '0;
        end else begin
            mode_o <= pss_state;
            clks_since_ssb <= clks_since_ssb + 1'b1;

            // the detector always asks for the cell it reported last
            if (n_id_2_valid_i) begin
                requested_n_id_2_o <= n_id_2_i;
            end

            case (pss_state)
                SEARCH: begin
                    // full search over all three N_id_2
                    if (n_id_2_valid_i) begin
                        pss_state <= PAUSE;
                        clks_since_ssb <= pss_clk_t'(1);
                    end
                end
                PAUSE: begin
                    // detector sleeps until shortly before the next SSB burst
                    if (clks_since_ssb > pss_clk_t'(CLKS_20MS - CLKS_EARLY)) begin
                        pss_state <= FIND;
                    end
                end
                FIND: begin
                    if (n_id_2_valid_i) begin
                        pss_state <= PAUSE;
                        clks_since_ssb <= pss_clk_t'(1);
                    end else if (clks_since_ssb > pss_clk_t'(CLKS_20MS + CLKS_LATE)) begin
                        // SSB missed its window, start a fresh search
                        pss_state <= SEARCH;
                    end
                end
                default: begin
                    pss_state <= SEARCH;
                end
            endcase
        end
    end

endmodule

// File: hdl/stream_output.sv
module stream_output (
    input  logic                          clk_i,
    input  logic                          reset_ni,
    symbol_timing_if.out                  timing_io,
    input  sync_ctrl_pkg::sample_t        data_i,
    input  logic                          n_id_2_valid_i,
    input  sync_ctrl_pkg::sync_state_t    state_i,
    input  nr_numerology_pkg::frame_pos_t pos_i,
    output sync_ctrl_pkg::sample_t        data_o,
    output nr_numerology_pkg::tuser_t     tuser_o,
    output logic                          valid_o,
    output logic                          last_o,
    output logic                          symbol_start_o,
    output logic                          ssb_start_o
);
    import sync_ctrl_pkg::*;

    logic    accept;
    sample_t s1_data;
    logic    s1_valid;
    logic    s1_first;
    logic    s1_last;
    logic    s1_ssb;

    // samples go out once timing is known, the anchor itself included
    assign accept = timing_io.sample_valid && ((state_i != WAIT_SSB) || timing_io.anchor);

    always_ff @(posedge clk_i) begin
        s1_data <= data_i;
        data_o <= s1_data;
        // tracker has already updated pos and cp_len for the sample in stage one
        tuser_o <= {pos_i, timing_io.cp_len};
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            s1_valid <= 1'b0;
            s1_first <= 1'b0;
            s1_last <= 1'b0;
            s1_ssb <= 1'b0;
            valid_o <= 1'b0;
            last_o <= 1'b0;
            symbol_start_o <= 1'b0;
            ssb_start_o <= 1'b0;
        end else begin
            s1_valid <= accept;
            s1_first <= accept && timing_io.first;
            s1_last <= accept && timing_io.last;
            // once locked, further PSS hits are no longer flagged downstream
            s1_ssb <= accept && n_id_2_valid_i && (state_i != SYNCED);
            valid_o <= s1_valid;
            last_o <= s1_last;
            symbol_start_o <= s1_first;
            ssb_start_o <= s1_ssb;
        end
    end

endmodule

// File: hdl/symbol_timer.sv
module symbol_timer (
    input  logic                      clk_i,
    input  logic                      reset_ni,
    symbol_timing_if.timer            timing_io,
    input  sync_ctrl_pkg::sync_state_t state_i
);
    import nr_numerology_pkg::*;
    import sync_ctrl_pkg::*;

    // position of the next offered sample within its symbol, CP included
    sample_cnt_t sample_cnt;
    sample_cnt_t last_idx;
    logic        running;

    // the count only moves once symbol timing has been fixed by an SSB
    assign running = (state_i != WAIT_SSB);

    assign last_idx = sample_cnt_t'(FFT_LEN - 1) + sample_cnt_t'(timing_io.cp_len);

    // the anchor sample is sample 0 no matter where the counter stands
    assign timing_io.first = timing_io.anchor ||
                             (timing_io.sample_valid && running && (sample_cnt == '0));

    assign timing_io.last = timing_io.sample_valid && running && (sample_cnt == last_idx);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sample_cnt <= '0;
        end else if (timing_io.anchor) begin
            sample_cnt <= sample_cnt_t'(1);
        end else if (timing_io.sample_valid && running) begin
            if (timing_io.last) begin
                sample_cnt <= '0;
            end else begin
                sample_cnt <= sample_cnt + 1'b1;
            end
        end
    end

endmodule

// File: hdl/symbol_timing_if.sv
interface symbol_timing_if;
    import nr_numerology_pkg::*;

    // accepted input sample in this cycle
    logic    sample_valid;
    // first SSB sample, restarts the symbol timing
    logic    anchor;
    // CP length of the symbol currently being counted
    cp_len_t cp_len;
    // accepted sample is the first or last of its symbol
    logic    first;
    logic    last;

    modport timer (input sample_valid, input anchor, input cp_len, output first, output last);
    modport tracker (input sample_valid, input first, input last, output anchor, output cp_len);
    modport out (input sample_valid, input anchor, input cp_len, input first, input last);

endinterface

// File: hdl/sync_ctrl_pkg.sv
package sync_ctrl_pkg;

    localparam int unsigned CLK_FREQ = 3840000;

    // PSS timing in clock cycles, one SSB burst every 20 ms
    localparam int unsigned CLKS_20MS = CLK_FREQ / 50;
    // wake up 0.1 ms early and keep looking 0.1 ms past the expected SSB
    localparam int unsigned CLKS_EARLY = CLK_FREQ / 10000;
    localparam int unsigned CLKS_LATE = CLK_FREQ / 10000;

    typedef logic [16:0] pss_clk_t;
    // one complex sample, I and Q packed in 32 bits
    typedef logic [31:0] sample_t;
    typedef logic [1:0] n_id_2_t;

    typedef enum logic [1:0] {
        SEARCH = 2'd0,
        FIND   = 2'd1,
        PAUSE  = 2'd2
    } pss_mode_t;

    typedef enum logic [1:0] {
        WAIT_SSB,
        WAIT_IBAR,
        SYNCED
    } sync_state_t;

endpackage
